// ==== source/pma_defs.svh ====
/*
 * Global sizes for the PMA checking unit.
 * Included by the package, the RTL and the testbench.
 */

`ifndef PMA_DEFS_SVH
`define PMA_DEFS_SVH

// register width, also the width of one config data word
`define PMA_XLEN 32

// physical address width
// region address words carry bits PLEN-1 down to 2
`define PMA_PLEN 34

// number of regions in the table
`define PMA_CNT 8

`endif

// ==== source/pma_pkg.sv ====
/*
 * Types shared by the PMA unit and its testbench.
 * Attribute layout and the dual-view configuration word live here.
 */

`include "pma_defs.svh"

package pma_pkg;

  // memory type of a region, EMPTY means nothing there
  typedef enum logic [1:0] {
    MEM_TYPE_EMPTY = 2'd0,
    MEM_TYPE_MAIN  = 2'd1,
    MEM_TYPE_IO    = 2'd2,
    MEM_TYPE_TCM   = 2'd3
  } mem_type_t;

  // atomic support level, passed through only
  typedef enum logic [1:0] {
    AMO_TYPE_NONE    = 2'd0,
    AMO_TYPE_SWAP    = 2'd1,
    AMO_TYPE_LOGICAL = 2'd2,
    AMO_TYPE_ARITH   = 2'd3
  } amo_type_t;

  // region address matching mode
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } addr_mode_t;

  // transfer size, 1/2/4/8 bytes
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3
  } xfer_size_t;

  // 14 bit attribute word, msb first
  typedef struct packed {
    mem_type_t  mem_type;
    amo_type_t  amo_type;
    logic       r;
    logic       w;
    logic       x;
    logic       c;    // cacheable
    logic       cc;   // cache coherent
    logic       ri;   // read idempotent
    logic       wi;   // write idempotent
    logic       m;    // misaligned allowed
    addr_mode_t a;
  } pmacfg_t;

  // one config data word, read as a region address or as attributes
  typedef union packed {
    logic [`PMA_XLEN-1:0] adr;
    struct packed {
      logic [`PMA_XLEN-$bits(pmacfg_t)-1:0] pad;
      pmacfg_t                              cfg;
    } attr;
  } cfg_word_u;

endpackage

// ==== source/pma_cfg_table.sv ====
/*
 * Region table of the PMA unit.
 * Holds one attribute word and one address word per region.
 * Written through a config port with no handshake, sel picks the view.
 */

`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_cfg_table
  import pma_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // config write port
  input  logic                          cfg_we_i,
  input  logic [$clog2((`PMA_CNT > 1) ? `PMA_CNT : 2)-1:0] cfg_idx_i,
  input  logic                          cfg_sel_i,
  input  cfg_word_u                     cfg_wdata_i,

  // table contents per region
  output pmacfg_t                       pma_cfg_o [`PMA_CNT],
  output logic    [`PMA_XLEN-1:0]       pma_adr_o [`PMA_CNT]
);

  // index beyond the table is ignored
  logic idx_ok;

  assign idx_ok = (int'(cfg_idx_i) < `PMA_CNT);

  ////////////////////////////////////////
  // table registers
  ////////////////////////////////////////

  // reset leaves every region OFF and EMPTY
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int n = 0; n < `PMA_CNT; n++)
      begin
        pma_cfg_o[n] <= '0;
        pma_adr_o[n] <= '0;
      end
    end
    else if (cfg_we_i && idx_ok)
    begin
      // sel high writes the address view and sel low the attribute view
      if (cfg_sel_i)
        pma_adr_o[cfg_idx_i] <= cfg_wdata_i.adr;
      else
        pma_cfg_o[cfg_idx_i] <= cfg_wdata_i.attr.cfg;
    end
  end

endmodule

// ==== source/pma_req_stage.sv ====
/*
 * Request input register of the PMA unit.
 * Accepts one request per valid/ready transfer and holds it for the checker.
 * Precomputes the byte bounds of the access and the natural alignment flag.
 */

`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_req_stage
  import pma_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // request channel
  input  logic                 req_valid_i,
  input  logic [`PMA_PLEN-1:0] req_adr_i,
  input  xfer_size_t           req_size_i,
  input  logic                 req_we_i,
  input  logic                 req_instr_i,
  output logic                 req_ready_o,

  // response stage can take a result
  input  logic                 adv_i,

  // registered request towards the checker
  output logic                 chk_valid_o,
  output logic [`PMA_PLEN-1:0] acc_lb_o,
  output logic [`PMA_PLEN-1:0] acc_ub_o,
  output logic                 chk_we_o,
  output logic                 chk_instr_o,
  output logic                 chk_misaligned_o
);

  logic [`PMA_PLEN-1:0] last_ofs;
  logic                 misaligned;

  // byte offset of the last byte, and low address bits that must be zero
  always_comb
  begin
    case (req_size_i)
      HWORD:
      begin
        last_ofs   = `PMA_PLEN'(1);
        misaligned = req_adr_i[0];
      end
      WORD:
      begin
        last_ofs   = `PMA_PLEN'(3);
        misaligned = |req_adr_i[1:0];
      end
      DWORD:
      begin
        last_ofs   = `PMA_PLEN'(7);
        misaligned = |req_adr_i[2:0];
      end
      // byte, and any unknown encoding taken as a byte
      default:
      begin
        last_ofs   = '0;
        misaligned = 1'b0;
      end
    endcase
  end

  // empty, or the held request leaves this cycle
  assign req_ready_o = ~chk_valid_o | adv_i;

  ////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////

  // occupancy
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      chk_valid_o <= 1'b0;
    else if (req_ready_o)
      chk_valid_o <= req_valid_i;
  end

  // payload, only on a transfer
  always_ff @(posedge clk_i)
  begin
    if (req_valid_i && req_ready_o)
    begin
      acc_lb_o         <= req_adr_i;
      acc_ub_o         <= req_adr_i + last_ofs;
      chk_we_o         <= req_we_i;
      chk_instr_o      <= req_instr_i;
      chk_misaligned_o <= misaligned;
    end
  end

endmodule

// ==== source/pma_checker.sv ====
/*
 * Combinational PMA check.
 * Matches the held access against all regions, lowest index wins,
 * and returns sanitized attributes plus exception/misaligned/cacheable.
 */

`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_checker
  import pma_pkg::*;
(
  // region table
  input  pmacfg_t                 pma_cfg_i [`PMA_CNT],
  input  logic    [`PMA_XLEN-1:0] pma_adr_i [`PMA_CNT],

  // access from the request stage
  input  logic                    chk_valid_i,
  input  logic    [`PMA_PLEN-1:0] acc_lb_i,
  input  logic    [`PMA_PLEN-1:0] acc_ub_i,
  input  logic                    chk_we_i,
  input  logic                    chk_instr_i,
  input  logic                    chk_misaligned_i,

  // result
  output logic                    exception_o,
  output logic                    misaligned_o,
  output logic                    cacheable_o,
  output pmacfg_t                 pma_o
);

  localparam int PLEN  = `PMA_PLEN;
  localparam int CNT   = `PMA_CNT;
  localparam int IDX_W = (CNT > 1) ? $clog2(CNT) : 1;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // log2 of region size in words
  // NA4 is one word, NAPOT is 2^(trailing ones + 1) words
  function automatic int napot_bits(input logic na4, input logic [PLEN-1:2] adr);
    int   n;
    logic run;
    n   = 0;
    run = 1'b1;
    if (!na4)
    begin
      for (int k = 0; k < PLEN-2; k++)
      begin
        run = run & adr[k+2];
        if (run)
          n++;
      end
      n++;
    end
    return n;
  endfunction

  pmacfg_t               pmacfg   [CNT];
  logic    [PLEN-1:2]    pma_lb   [CNT];
  logic    [PLEN-1:2]    pma_ub   [CNT];
  logic    [PLEN-1:2]    prev_adr;
  logic    [PLEN-1:2]    mask;
  int                    sh;
  logic    [CNT-1:0]     match_all;
  logic    [IDX_W-1:0]   sel_idx;
  pmacfg_t               matched;

  ////////////////////////////////////////
  // attribute sanitizing
  ////////////////////////////////////////

  always_comb
  begin
    for (int n = 0; n < CNT; n++)
    begin
      pmacfg[n] = pma_cfg_i[n];
      // nothing mapped: treat as io, no access
      if (pma_cfg_i[n].mem_type == MEM_TYPE_EMPTY)
      begin
        pmacfg[n].mem_type = MEM_TYPE_IO;
        pmacfg[n].amo_type = AMO_TYPE_NONE;
        pmacfg[n].r        = 1'b0;
        pmacfg[n].w        = 1'b0;
        pmacfg[n].x        = 1'b0;
      end
      // cacheable only in main memory, coherent only when cacheable
      pmacfg[n].c  = (pma_cfg_i[n].mem_type == MEM_TYPE_MAIN) & pma_cfg_i[n].c;
      pmacfg[n].cc = pma_cfg_i[n].cc & pmacfg[n].c;
      // idempotency is only a question for io
      pmacfg[n].ri = (pma_cfg_i[n].mem_type == MEM_TYPE_IO) ? pma_cfg_i[n].ri : 1'b1;
      pmacfg[n].wi = (pma_cfg_i[n].mem_type == MEM_TYPE_IO) ? pma_cfg_i[n].wi : 1'b1;
    end
  end

  ////////////////////////////////////////
  // region bounds and matching
  ////////////////////////////////////////

  // bounds in word units, ub is exclusive
  always_comb
  begin
    prev_adr = '0;
    for (int n = 0; n < CNT; n++)
    begin
      sh   = napot_bits(pmacfg[n].a == NA4, pma_adr_i[n]);
      mask = {(PLEN-2){1'b1}} << sh;
      case (pmacfg[n].a)
        TOR:
        begin
          // previous region's address word, zero below region 0
          pma_lb[n] = prev_adr;
          pma_ub[n] = pma_adr_i[n];
        end
        NA4, NAPOT:
        begin
          pma_lb[n] = pma_adr_i[n] & mask;
          pma_ub[n] = (pma_adr_i[n] + ((PLEN-2)'(1) << sh)) & mask;
        end
        default:
        begin
          pma_lb[n] = '0;
          pma_ub[n] = '0;
        end
      endcase
      // every byte of the access inside the region
      match_all[n] = (pmacfg[n].a != OFF)              &&
                     (acc_lb_i[PLEN-1:2] >= pma_lb[n]) &&
                     (acc_ub_i[PLEN-1:2] <  pma_ub[n]);
      prev_adr = pma_adr_i[n];
    end
  end

  // lowest numbered match, region 0 when none
  always_comb
  begin
    sel_idx = '0;
    for (int n = CNT-1; n >= 0; n--)
    begin
      if (match_all[n])
        sel_idx = IDX_W'(n);
    end
  end

  assign matched = pmacfg[sel_idx];
  assign pma_o   = matched;

  ////////////////////////////////////////
  // exceptions and flags
  ////////////////////////////////////////

  // fetch needs x, store needs w, data load needs r
  assign exception_o = chk_valid_i & (~|match_all                              |
                                      ( chk_instr_i              & ~matched.x) |
                                      ( chk_we_i                 & ~matched.w) |
                                      (~chk_we_i & ~chk_instr_i  & ~matched.r));

  // region may allow unaligned accesses
  assign misaligned_o = chk_misaligned_i & ~matched.m;

  // c already implies main memory after sanitizing
  assign cacheable_o = matched.c;

endmodule

// ==== source/pma_resp_stage.sv ====
/*
 * Response output register of the PMA unit.
 * Captures one check result and holds it until the host takes it.
 */

`timescale 1ns/1ps

module pma_resp_stage
  import pma_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  // result from the checker
  input  logic    chk_valid_i,
  input  logic    exception_i,
  input  logic    misaligned_i,
  input  logic    cacheable_i,
  input  pmacfg_t pma_i,

  // request stage may move on
  output logic    adv_o,

  // response channel
  input  logic    resp_ready_i,
  output logic    resp_valid_o,
  output logic    resp_exception_o,
  output logic    resp_misaligned_o,
  output logic    resp_cacheable_o,
  output pmacfg_t resp_attr_o
);

  // empty, or current response is taken this cycle
  assign adv_o = ~resp_valid_o | resp_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_valid_o <= 1'b0;
    else if (adv_o)
      resp_valid_o <= chk_valid_i;
  end

  // hold payload stable under back-pressure
  always_ff @(posedge clk_i)
  begin
    if (adv_o && chk_valid_i)
    begin
      resp_exception_o  <= exception_i;
      resp_misaligned_o <= misaligned_i;
      resp_cacheable_o  <= cacheable_i;
      resp_attr_o       <= pma_i;
    end
  end

endmodule

// ==== source/pma_unit_top.sv ====
/*
 * Top level of the PMA checking unit.
 * Region table and request register feed the checker,
 * the response register presents the result. Two requests max in flight.
 */

`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_unit_top
  import pma_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // config port
  input  logic                 cfg_we_i,
  input  logic [$clog2((`PMA_CNT > 1) ? `PMA_CNT : 2)-1:0] cfg_idx_i,
  input  logic                 cfg_sel_i,
  input  cfg_word_u            cfg_wdata_i,

  // request channel
  input  logic                 req_valid_i,
  input  logic [`PMA_PLEN-1:0] req_adr_i,
  input  xfer_size_t           req_size_i,
  input  logic                 req_we_i,
  input  logic                 req_instr_i,
  output logic                 req_ready_o,

  // response channel
  input  logic                 resp_ready_i,
  output logic                 resp_valid_o,
  output logic                 resp_exception_o,
  output logic                 resp_misaligned_o,
  output logic                 resp_cacheable_o,
  output pmacfg_t              resp_attr_o
);

  // table outputs
  pmacfg_t              pma_cfg [`PMA_CNT];
  logic [`PMA_XLEN-1:0] pma_adr [`PMA_CNT];

  // request stage -> checker
  logic                 chk_valid;
  logic [`PMA_PLEN-1:0] acc_lb;
  logic [`PMA_PLEN-1:0] acc_ub;
  logic                 chk_we;
  logic                 chk_instr;
  logic                 chk_misaligned;

  // checker -> response stage
  logic                 exception;
  logic                 misaligned;
  logic                 cacheable;
  pmacfg_t              pma_attr;
  logic                 adv;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  pma_cfg_table u_pma_cfg_table (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .pma_cfg_o   (pma_cfg),
    .pma_adr_o   (pma_adr)
  );

  pma_req_stage u_pma_req_stage (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_valid_i      (req_valid_i),
    .req_adr_i        (req_adr_i),
    .req_size_i       (req_size_i),
    .req_we_i         (req_we_i),
    .req_instr_i      (req_instr_i),
    .req_ready_o      (req_ready_o),
    .adv_i            (adv),
    .chk_valid_o      (chk_valid),
    .acc_lb_o         (acc_lb),
    .acc_ub_o         (acc_ub),
    .chk_we_o         (chk_we),
    .chk_instr_o      (chk_instr),
    .chk_misaligned_o (chk_misaligned)
  );

  // processing
  pma_checker u_pma_checker (
    .pma_cfg_i        (pma_cfg),
    .pma_adr_i        (pma_adr),
    .chk_valid_i      (chk_valid),
    .acc_lb_i         (acc_lb),
    .acc_ub_i         (acc_ub),
    .chk_we_i         (chk_we),
    .chk_instr_i      (chk_instr),
    .chk_misaligned_i (chk_misaligned),
    .exception_o      (exception),
    .misaligned_o     (misaligned),
    .cacheable_o      (cacheable),
    .pma_o            (pma_attr)
  );

  // output side
  pma_resp_stage u_pma_resp_stage (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .chk_valid_i       (chk_valid),
    .exception_i       (exception),
    .misaligned_i      (misaligned),
    .cacheable_i       (cacheable),
    .pma_i             (pma_attr),
    .adv_o             (adv),
    .resp_ready_i      (resp_ready_i),
    .resp_valid_o      (resp_valid_o),
    .resp_exception_o  (resp_exception_o),
    .resp_misaligned_o (resp_misaligned_o),
    .resp_cacheable_o  (resp_cacheable_o),
    .resp_attr_o       (resp_attr_o)
  );

endmodule

// ==== dv/pma_unit_properties.sv ====
/*
 * Concurrent checks on the PMA unit top level.
 * Bound into every pma_unit_top instance.
 */

`timescale 1ns/1ps

module pma_unit_properties
  import pma_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    req_ready_o,
  input logic    resp_ready_i,
  input logic    resp_valid_o,
  input logic    resp_exception_o,
  input logic    resp_misaligned_o,
  input logic    resp_cacheable_o,
  input pmacfg_t resp_attr_o
);

  // failed assertions so far, the testbench reads it at the end
  int fail_cnt = 0;

  // stalled response holds valid and payload
  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (resp_valid_o && !resp_ready_i) |=>
      (resp_valid_o && $stable(resp_exception_o) && $stable(resp_misaligned_o) &&
       $stable(resp_cacheable_o) && $stable(resp_attr_o)))
  else
  begin
    fail_cnt++;
    $error("response changed while resp_ready_i was low");
  end

  // output stage empty after reset
  a_reset_resp: assert property (@(posedge clk_i) !rst_n_i |=> !resp_valid_o)
  else
  begin
    fail_cnt++;
    $error("resp_valid_o high in the cycle after reset");
  end

  // input stage empty, so ready
  a_reset_ready: assert property (@(posedge clk_i) !rst_n_i |=> req_ready_o)
  else
  begin
    fail_cnt++;
    $error("req_ready_o low in the cycle after reset");
  end

endmodule

bind pma_unit_top pma_unit_properties u_pma_unit_properties (.*);

// ==== dv/pma_unit_tb.sv ====
/*
 * Testbench for the PMA checking unit.
 * Replays config writes and requests from dv/pma_input.txt, stalls the
 * response channel at random and checks every response in request order.
 */

`timescale 1ns/1ps

`include "pma_defs.svh"

module pma_unit_tb
  import pma_pkg::*;
();

  localparam int IDX_W         = (`PMA_CNT > 1) ? $clog2(`PMA_CNT) : 1;
  localparam int REQ_TIMEOUT   = 1000;
  localparam int DRAIN_TIMEOUT = 1000;

  // expected response of one request line
  typedef struct packed {
    logic        exc;
    logic        mis;
    logic        cach;
    logic [13:0] attr;
  } resp_exp_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 cfg_we_i;
  logic [IDX_W-1:0]     cfg_idx_i;
  logic                 cfg_sel_i;
  cfg_word_u            cfg_wdata_i;
  logic                 req_valid_i;
  logic [`PMA_PLEN-1:0] req_adr_i;
  xfer_size_t           req_size_i;
  logic                 req_we_i;
  logic                 req_instr_i;
  logic                 req_ready_o;
  logic                 resp_ready_i;
  logic                 resp_valid_o;
  logic                 resp_exception_o;
  logic                 resp_misaligned_o;
  logic                 resp_cacheable_o;
  pmacfg_t              resp_attr_o;

  // responses still owed by the DUT in request order
  resp_exp_t exp_q [$];

  int req_cnt       = 0;
  int resp_cnt      = 0;
  int mismatch_cnt  = 0;
  int other_err_cnt = 0;
  bit timed_out     = 1'b0;

  pma_unit_top u_pma_unit_top (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .cfg_we_i          (cfg_we_i),
    .cfg_idx_i         (cfg_idx_i),
    .cfg_sel_i         (cfg_sel_i),
    .cfg_wdata_i       (cfg_wdata_i),
    .req_valid_i       (req_valid_i),
    .req_adr_i         (req_adr_i),
    .req_size_i        (req_size_i),
    .req_we_i          (req_we_i),
    .req_instr_i       (req_instr_i),
    .req_ready_o       (req_ready_o),
    .resp_ready_i      (resp_ready_i),
    .resp_valid_o      (resp_valid_o),
    .resp_exception_o  (resp_exception_o),
    .resp_misaligned_o (resp_misaligned_o),
    .resp_cacheable_o  (resp_cacheable_o),
    .resp_attr_o       (resp_attr_o)
  );

  // 100 ns period
  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
    begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
      mismatch_cnt++;
    end
  endtask

  task automatic note_timeout(input string what, input int cycles);
    $display("ERROR: gave up waiting for %s after %0d cycles at %0t", what, cycles, $time);
    other_err_cnt++;
    timed_out = 1'b1;
  endtask

  // one write taken at the next edge
  task automatic write_cfg(input logic [IDX_W-1:0] idx, input logic sel,
                           input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx;
    cfg_sel_i   = sel;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i    = 1'b0;
  endtask

  // wait until every queued response came back
  task automatic drain_responses();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && !timed_out)
    begin
      cycles++;
      if (cycles > DRAIN_TIMEOUT)
        note_timeout("outstanding responses", cycles);
      else
      begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic send_request(input logic [`PMA_PLEN-1:0] adr, input logic [2:0] size,
                              input logic we, input logic instr, input resp_exp_t want);
    int cycles;
    cycles      = 0;
    req_valid_i = 1'b1;
    req_adr_i   = adr;
    req_size_i  = xfer_size_t'(size);
    req_we_i    = we;
    req_instr_i = instr;
    exp_q.push_back(want);
    req_cnt++;
    // ready seen mid-cycle decides the transfer at the next edge
    @(negedge clk_i);
    while (!req_ready_o && !timed_out)
    begin
      cycles++;
      if (cycles > REQ_TIMEOUT)
        note_timeout("req_ready_o", cycles);
      else
        @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // C lines write the table and R lines issue a request
  task automatic apply_line(input string line);
    logic [IDX_W-1:0]     idx;
    logic                 sel;
    logic [31:0]          data;
    logic [`PMA_PLEN-1:0] adr;
    logic [2:0]           size;
    logic                 we;
    logic                 instr;
    logic                 exc;
    logic                 mis;
    logic                 cach;
    logic [13:0]          attr;
    resp_exp_t            want;
    int                   n;
    if (line.getc(0) == "C")
    begin
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", idx, sel, data);
      if (n != 3)
      begin
        $display("ERROR: config line cannot be read: %s", line);
        other_err_cnt++;
      end
      else
      begin
        // table only changes with nothing in flight
        drain_responses();
        if (!timed_out)
          write_cfg(idx, sel, data);
      end
    end
    else if (line.getc(0) == "R")
    begin
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                  adr, size, we, instr, exc, mis, cach, attr);
      if (n != 8)
      begin
        $display("ERROR: request line cannot be read: %s", line);
        other_err_cnt++;
      end
      else
      begin
        want = '{exc: exc, mis: mis, cach: cach, attr: attr};
        send_request(adr, size, we, instr, want);
      end
    end
  endtask

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  // random back-pressure on the response channel
  initial
  begin : ready_gen
    int unsigned seed_ret;
    seed_ret     = $urandom(32'hf6b7_dbe4);
    resp_ready_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #1;
      // ready about three cycles in four
      resp_ready_i = ($urandom % 4) != 0;
    end
  end

  always @(posedge clk_i)
  begin : resp_monitor
    resp_exp_t want;
    if (rst_n_i && resp_valid_o && resp_ready_i)
    begin
      resp_cnt++;
      if (exp_q.size() == 0)
      begin
        $display("ERROR: response at %0t with no request outstanding", $time);
        other_err_cnt++;
      end
      else
      begin
        want = exp_q.pop_front();
        check_value($sformatf("resp %0d exception", resp_cnt),
                    32'(resp_exception_o), 32'(want.exc));
        check_value($sformatf("resp %0d misaligned", resp_cnt),
                    32'(resp_misaligned_o), 32'(want.mis));
        check_value($sformatf("resp %0d cacheable", resp_cnt),
                    32'(resp_cacheable_o), 32'(want.cach));
        check_value($sformatf("resp %0d attr", resp_cnt),
                    {18'd0, resp_attr_o}, {18'd0, want.attr});
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin : stimulus
    string line;
    int    fd;
    int    got;
    int    assert_fails;
    rst_n_i     = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_idx_i   = '0;
    cfg_sel_i   = 1'b0;
    cfg_wdata_i = '0;
    req_valid_i = 1'b0;
    req_adr_i   = '0;
    req_size_i  = BYTE;
    req_we_i    = 1'b0;
    req_instr_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    fd = $fopen("dv/pma_input.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open dv/pma_input.txt");
      other_err_cnt++;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        got = $fgets(line, fd);
        if (got > 0)
          apply_line(line);
      end
      $fclose(fd);
      drain_responses();
      // a repeated last response would keep the output stage full
      if (!timed_out)
        check_value("resp_valid_o after last response", 32'(resp_valid_o), 32'd0);
    end
    // every request line answered exactly once
    check_value("response count", resp_cnt, req_cnt);
    assert_fails = u_pma_unit_top.u_pma_unit_properties.fail_cnt;
    if (assert_fails != 0)
    begin
      $display("ERROR: %0d assertion failures on the DUT", assert_fails);
      other_err_cnt += assert_fails;
    end
    $display("requests %0d, responses %0d, mismatches %0d, other errors %0d",
             req_cnt, resp_cnt, mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== dv/pma_input.txt ====
# C <region> <sel: 0 attr, 1 addr> <data word>
# R <addr> <size> <we> <instr> then expected <exc> <mis> <cach> <attr>
# after reset, every region OFF
R 000000100 2 0 0 1 0 0 2018
R 000000202 1 1 0 1 0 0 2018
R 000000003 2 0 1 1 1 0 2018
# region table, region 1 attr word carries a nonzero pad
C 0 1 00000400
C 0 0 000013E1
C 1 1 00000800
C 1 0 FFFC234A
C 2 1 000011FF
C 2 0 00001287
C 3 1 000003FF
C 3 0 00001FC7
C 4 1 00004000
C 4 0 00000382
C 5 1 00008000
C 5 0 00003341
# matching, permissions, alignment and cacheability
R 000000100 2 0 0 0 0 1 13F9
R 000000FFE 2 0 0 0 0 1 1FDF
R 000001FFE 2 0 0 1 1 1 13F9
R 000002000 2 1 0 0 0 0 230A
R 000002000 2 0 1 1 0 0 230A
R 000002001 1 0 0 0 1 0 230A
R 000002002 2 0 0 1 1 1 13F9
R 000004000 2 0 1 0 0 0 129F
R 000004100 2 1 0 1 0 0 129F
R 000004102 2 0 0 0 0 0 129F
R 000004FFE 2 0 0 1 1 1 13F9
R 000010000 0 0 0 1 0 0 201A
R 000010004 2 1 0 0 0 0 3319
R 000010006 2 0 0 0 1 0 3319
R 00001FFFC 2 0 1 1 0 0 3319
R 00001FFFE 2 0 0 1 1 1 13F9
R 300000000 0 0 0 1 0 1 13F9

// ==== list.f ====
+incdir+source
source/pma_pkg.sv
source/pma_cfg_table.sv
source/pma_req_stage.sv
source/pma_checker.sv
source/pma_resp_stage.sv
source/pma_unit_top.sv
dv/pma_unit_properties.sv
dv/pma_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the PMA unit testbench with Verilator
# all paths are relative to the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert -f list.f --top-module pma_unit_tb -o pma_unit_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/pma_unit_sim +verilator+error+limit+100 > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
